// File: hdl/core_alu.sv
`default_nettype none

module core_alu import core_pkg::*; (
	input  alu_op               op,
	input  logic [core_w - 1:0] a,
	input  logic [core_w - 1:0] base,
	input  logic [7:0]          shift,
	input  shift_kind           kind,
	input  logic                c_in,

	output logic [core_w - 1:0] q,
	output psr_flags            nzcv,
	output logic                v_valid
);

	logic [core_w - 1:0] b;
	logic [core_w - 1:0] op_a;
	logic [core_w - 1:0] op_b;
	logic [core_w - 1:0] add_b;
	logic [core_w - 1:0] cin_add;
	logic [core_w - 1:0] q_add;
	logic [core_w - 1:0] q_and;
	logic [core_w - 1:0] q_orr;
	logic [core_w - 1:0] q_xor;
	logic                c_shift;
	logic                c_add;
	logic                v_add;
	logic                c_out;
	logic                swap;
	logic                sub;
	logic                bic;
	logic                cin_bit;

	core_alu_shifter u_shifter (
		.base (base),
		.shift(shift),
		.kind (kind),
		.c_in (c_in),
		.b    (b),
		.c    (c_shift)
	);

	assign op_a    = swap ? b : a;
	assign op_b    = swap ? a : b;
	assign add_b   = sub ? ~op_b : op_b;    // a - b is done as a + ~b + 1
	assign cin_add = {{(core_w - 1){1'b0}}, cin_bit};

	core_alu_add u_add (
		.a   (op_a),
		.b   (add_b),
		.c_in(cin_add),
		.q   (q_add),
		.c   (c_add),
		.v   (v_add)
	);

	assign q_and = a & (bic ? ~b : b);
	assign q_orr = a | b;
	assign q_xor = a ^ b;

	always_comb begin
		swap    = 1'b0;
		sub     = 1'b0;
		bic     = 1'b0;
		cin_bit = 1'b0;

		case (op)
			alu_sub, alu_cmp: begin
				sub     = 1'b1;
				cin_bit = 1'b1;
			end
			alu_rsb: begin
				swap    = 1'b1;
				sub     = 1'b1;
				cin_bit = 1'b1;
			end
			alu_sbc: begin
				sub     = 1'b1;
				cin_bit = c_in;   // a + ~b + c is a - b - not c
			end
			alu_rsc: begin
				swap    = 1'b1;
				sub     = 1'b1;
				cin_bit = c_in;
			end
			alu_adc:
				cin_bit = c_in;
			alu_bic:
				bic = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		unique case (op)
			alu_sub, alu_rsb, alu_add, alu_adc, alu_sbc, alu_rsc, alu_cmp, alu_cmn:
				q = q_add;
			alu_and, alu_tst, alu_bic:
				q = q_and;
			alu_eor, alu_teq:
				q = q_xor;
			alu_orr:
				q = q_orr;
			alu_mov:
				q = b;
			alu_mvn:
				q = ~b;
		endcase

		unique case (op)
			alu_sub, alu_rsb, alu_add, alu_adc, alu_sbc, alu_rsc, alu_cmp, alu_cmn: begin
				c_out   = c_add;
				v_valid = 1'b1;
			end
			alu_and, alu_eor, alu_tst, alu_teq, alu_orr, alu_mov, alu_bic, alu_mvn: begin
				c_out   = c_shift;   // logical ops take C from the shifter
				v_valid = 1'b0;
			end
		endcase
	end

	assign nzcv = '{n: q[core_w - 1], z: (q == '0), c: c_out, v: v_valid & v_add};

	// arithmetic opcodes are 2..7 and 10..11 in the ARM encoding
	always_comb begin
		assert final (v_valid == (op[3:1] inside {3'b001, 3'b010, 3'b011, 3'b101}))
			else $error("v_valid disagrees with the opcode class of %0d", op);
	end

endmodule

`default_nettype wire

// File: hdl/core_alu_add.sv
`default_nettype none

module core_alu_add import core_pkg::*; (
	input  logic [core_w - 1:0] a,
	input  logic [core_w - 1:0] b,
	input  logic [core_w - 1:0] c_in,

	output logic [core_w - 1:0] q,
	output logic                c,
	output logic                v
);

	logic [core_w:0] sum;

	// subtraction arrives here already inverted, so c is the ARM "no borrow" carry
	assign sum = {1'b0, a} + {1'b0, b} + {1'b0, c_in};

	assign q = sum[core_w - 1:0];
	assign c = sum[core_w];

	// same-signed operands that give a sum of the other sign overflowed
	assign v = (a[core_w - 1] == b[core_w - 1]) && (q[core_w - 1] != a[core_w - 1]);

endmodule

`default_nettype wire

// File: hdl/core_alu_shifter.sv
`default_nettype none

module core_alu_shifter import core_pkg::*; (
	input  logic [core_w - 1:0] base,
	input  logic [7:0]          shift,
	input  shift_kind           kind,
	input  logic                c_in,

	output logic [core_w - 1:0] b,
	output logic                c
);

	logic [core_sw - 1:0]    amt;
	logic [core_w:0]         lsl_w;
	logic [core_w:0]         lsr_w;
	logic [core_w:0]         asr_w;
	logic [2 * core_w - 1:0] rot_w;

	assign amt = shift[core_sw - 1:0];

	// one extra bit on each side catches the last bit shifted out
	assign lsl_w = {1'b0, base} << amt;              // {carry, result}
	assign lsr_w = {base, 1'b0} >> amt;              // {result, carry}
	assign asr_w = $signed({base, 1'b0}) >>> amt;
	assign rot_w = {base, base} >> amt;

	always_comb begin
		b = base;
		c = c_in;

		if (shift != 8'd0) begin
			unique case (kind)
				shift_lsl: begin
					if (shift < core_w) begin
						b = lsl_w[core_w - 1:0];
						c = lsl_w[core_w];
					end else if (shift == core_w) begin
						b = '0;
						c = base[0];
					end else begin
						b = '0;
						c = 1'b0;
					end
				end

				shift_lsr: begin
					if (shift < core_w) begin
						b = lsr_w[core_w:1];
						c = lsr_w[0];
					end else if (shift == core_w) begin
						b = '0;
						c = base[core_w - 1];
					end else begin
						b = '0;
						c = 1'b0;
					end
				end

				shift_asr: begin
					if (shift < core_w) begin
						b = asr_w[core_w:1];
						c = asr_w[0];
					end else begin
						// the sign fills everything, so the carry is the sign as well
						b = {core_w{base[core_w - 1]}};
						c = base[core_w - 1];
					end
				end

				shift_ror: begin
					b = rot_w[core_w - 1:0];
					c = rot_w[core_w - 1];   // the bit that wrapped into the top
				end
			endcase
		end
	end

	// a rotate by a nonzero multiple of the width moves nothing either
	always_comb begin
		assert final (amt != '0 || (shift != 8'd0 && kind != shift_ror) || b == base)
			else $error("shifter altered its operand with a zero effective amount");
	end

endmodule

`default_nettype wire

// File: hdl/core_exec.sv
`default_nettype none

module core_exec import core_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  alu_op               op,
	input  logic                set_flags,
	input  logic [core_w - 1:0] a,
	input  logic [core_w - 1:0] base,
	input  logic [7:0]          shift,
	input  shift_kind           kind,

	output logic [core_w - 1:0] q,
	output logic                out_valid,
	output psr_flags            flags
);

	logic [core_w - 1:0] q_next;
	psr_flags            nzcv_next;
	logic                v_valid;
	logic                flag_we;

	assign flag_we = in_valid & set_flags;

	core_alu u_alu (
		.op     (op),
		.a      (a),
		.base   (base),
		.shift  (shift),
		.kind   (kind),
		.c_in   (flags.c),   // ADC, SBC, RSC and the shifter see the stored carry
		.q      (q_next),
		.nzcv   (nzcv_next),
		.v_valid(v_valid)
	);

	core_psr u_psr (
		.clk      (clk),
		.rst_n    (rst_n),
		.we       (flag_we),
		.nzcv_next(nzcv_next),
		.v_valid  (v_valid),
		.flags    (flags)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q         <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
			if (in_valid)
				q <= q_next;   // q holds the last result between strobes
		end
	end

	a_valid_rise: assert property (
		@(posedge clk) disable iff (!rst_n)
		in_valid |=> out_valid
	) else $error("out_valid missing one cycle after a strobe");

	a_valid_fall: assert property (
		@(posedge clk) disable iff (!rst_n)
		!in_valid |=> !out_valid
	) else $error("out_valid raised without a strobe");

endmodule

`default_nettype wire

// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int core_w = 16;

	// low bits of the shift amount that select a position inside one word
	localparam int core_sw = $clog2(core_w);

	// data-processing opcodes in ARM encoding order
	typedef enum logic [3:0] {
		alu_and = 4'd0,
		alu_eor = 4'd1,
		alu_sub = 4'd2,
		alu_rsb = 4'd3,
		alu_add = 4'd4,
		alu_adc = 4'd5,
		alu_sbc = 4'd6,
		alu_rsc = 4'd7,
		alu_tst = 4'd8,   // flags only in the real ISA, q is still reported here
		alu_teq = 4'd9,
		alu_cmp = 4'd10,
		alu_cmn = 4'd11,
		alu_orr = 4'd12,
		alu_mov = 4'd13,
		alu_bic = 4'd14,
		alu_mvn = 4'd15
	} alu_op;

	typedef enum logic [1:0] {
		shift_lsl = 2'd0,
		shift_lsr = 2'd1,
		shift_asr = 2'd2,
		shift_ror = 2'd3
	} shift_kind;

	// n sits in the top bit so the struct reads as NZCV
	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

endpackage

`default_nettype wire

// File: hdl/core_psr.sv
`default_nettype none

module core_psr import core_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     we,
	input  psr_flags nzcv_next,
	input  logic     v_valid,

	output psr_flags flags
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flags <= '0;
		end else if (we) begin
			flags.n <= nzcv_next.n;
			flags.z <= nzcv_next.z;
			flags.c <= nzcv_next.c;
			if (v_valid)
				flags.v <= nzcv_next.v;   // logical ops leave V alone
		end
	end

	a_v_kept: assert property (
		@(posedge clk) disable iff (!rst_n)
		we && !v_valid |=> $stable(flags.v)
	) else $error("V flag changed on a write without a valid overflow");

endmodule

`default_nettype wire

// File: project.f
hdl/core_pkg.sv
hdl/core_alu_shifter.sv
hdl/core_alu_add.sv
hdl/core_alu.sv
hdl/core_psr.sv
hdl/core_exec.sv
test/tb_core_exec.sv

// File: test/tb_core_exec.sv
`default_nettype none

module tb_core_exec import core_pkg::*; ();

	localparam int clk_period  = 100;
	localparam int drive_delay = 10;
	localparam int n_random    = 2000;

	// arith 192, logic 48, shifter 48, gating 6, then the random burst
	localparam int n_vectors = 192 + 48 + 48 + 6 + n_random;

	logic                clk;
	logic                rst_n;
	logic                in_valid;
	alu_op               op;
	logic                set_flags;
	logic [core_w - 1:0] a;
	logic [core_w - 1:0] base;
	logic [7:0]          shift;
	shift_kind           kind;
	logic [core_w - 1:0] q;
	logic                out_valid;
	psr_flags            flags;

	psr_flags            model_flags;   // flags as they stand once the last strobe lands
	logic [core_w - 1:0] exp_q;
	logic                pend_valid;
	logic [core_w - 1:0] pend_q;
	psr_flags            pend_flags;
	logic                strobed;
	integer              seed;
	int                  errors;
	int                  vectors;
	int                  err_mark;
	int                  vec_mark;

	core_exec u_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.op       (op),
		.set_flags(set_flags),
		.a        (a),
		.base     (base),
		.shift    (shift),
		.kind     (kind),
		.q        (q),
		.out_valid(out_valid),
		.flags    (flags)
	);

	always #(clk_period / 2) clk = ~clk;

	// expected values move one edge along, next to the DUT result register
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pend_valid <= 1'b0;
			pend_q     <= '0;
			pend_flags <= '0;
		end else begin
			pend_valid <= in_valid;
			pend_q     <= exp_q;
			pend_flags <= model_flags;
		end
	end

	a_out_valid: assert property (@(posedge clk) disable iff (!rst_n) out_valid == pend_valid)
		else begin
			errors++;
			$display("** Error at %0t: out_valid is %b, expected %b", $time,
				$sampled(out_valid), $sampled(pend_valid));
		end

	a_result: assert property (@(posedge clk) disable iff (!rst_n) pend_valid |-> q == pend_q)
		else begin
			errors++;
			$display("** Error at %0t: q is %h, expected %h", $time, $sampled(q), $sampled(pend_q));
		end

	a_flags: assert property (@(posedge clk) disable iff (!rst_n) flags == pend_flags)
		else begin
			errors++;
			$display("** Error at %0t: NZCV is %b, expected %b", $time,
				$sampled(flags), $sampled(pend_flags));
		end

	a_reset_state: assert property (@(posedge clk) disable iff (!rst_n)
		!strobed |-> (!out_valid && q == '0 && flags == '0))
		else begin
			errors++;
			$display("** Error at %0t: outputs left their reset values before any strobe", $time);
		end

	// bit by bit, so every carry falls out as the last bit moved
	function automatic void shift_operand(
		input  logic [core_w - 1:0] val,
		input  logic [7:0]          amount,
		input  shift_kind           k,
		input  logic                c_in,
		output logic [core_w - 1:0] res,
		output logic                c
	);
		res = val;
		c   = c_in;
		for (int i = 0; i < int'(amount); i++) begin
			case (k)
				shift_lsl: begin
					c   = res[core_w - 1];
					res = res << 1;
				end
				shift_lsr: begin
					c   = res[0];
					res = res >> 1;
				end
				shift_asr: begin
					c   = res[0];
					res = {res[core_w - 1], res[core_w - 1:1]};
				end
				shift_ror: begin
					c   = res[0];
					res = {res[0], res[core_w - 1:1]};
				end
			endcase
		end
	endfunction

	function automatic void add_sub(
		input  logic [core_w - 1:0] x,
		input  logic [core_w - 1:0] y,
		input  logic                is_add,
		input  logic                carry,
		output logic [core_w - 1:0] res,
		output logic                c,
		output logic                v
	);
		int ures;
		int sres;
		int sx;
		int sy;
		sx = $signed(x);
		sy = $signed(y);
		if (is_add) begin
			ures = int'(x) + int'(y) + int'(carry);
			sres = sx + sy + int'(carry);
			c    = (ures > (1 << core_w) - 1);
		end else begin
			ures = int'(x) - int'(y) - int'(!carry);   // carry clear means a borrow comes in
			sres = sx - sy - int'(!carry);
			c    = (ures >= 0);
		end
		v   = (sres > (1 << (core_w - 1)) - 1) || (sres < -(1 << (core_w - 1)));
		res = ures[core_w - 1:0];
	endfunction

	function automatic void predict(
		input  alu_op               o,
		input  logic [core_w - 1:0] a_i,
		input  logic [core_w - 1:0] base_i,
		input  logic [7:0]          sh,
		input  shift_kind           k,
		input  logic                sf,
		input  psr_flags            f_in,
		output logic [core_w - 1:0] res,
		output psr_flags            f_out
	);
		logic [core_w - 1:0] b_s;
		logic                c_s;
		logic                c_r;
		logic                v_r;
		shift_operand(base_i, sh, k, f_in.c, b_s, c_s);
		c_r = c_s;
		v_r = f_in.v;   // logical ops keep the old overflow
		case (o)
			alu_and, alu_tst: res = a_i & b_s;
			alu_eor, alu_teq: res = a_i ^ b_s;
			alu_orr:          res = a_i | b_s;
			alu_bic:          res = a_i & ~b_s;
			alu_mov:          res = b_s;
			alu_mvn:          res = ~b_s;
			alu_add, alu_cmn: add_sub(a_i, b_s, 1'b1, 1'b0, res, c_r, v_r);
			alu_adc:          add_sub(a_i, b_s, 1'b1, f_in.c, res, c_r, v_r);
			alu_sub, alu_cmp: add_sub(a_i, b_s, 1'b0, 1'b1, res, c_r, v_r);
			alu_sbc:          add_sub(a_i, b_s, 1'b0, f_in.c, res, c_r, v_r);
			alu_rsb:          add_sub(b_s, a_i, 1'b0, 1'b1, res, c_r, v_r);
			alu_rsc:          add_sub(b_s, a_i, 1'b0, f_in.c, res, c_r, v_r);
		endcase
		f_out = f_in;
		if (sf) begin
			f_out.n = res[core_w - 1];
			f_out.z = (res == '0);
			f_out.c = c_r;
			f_out.v = v_r;
		end
	endfunction

	task automatic drive_vector(
		input alu_op               o,
		input logic [core_w - 1:0] a_i,
		input logic [core_w - 1:0] base_i,
		input logic [7:0]          sh,
		input shift_kind           k,
		input logic                sf
	);
		psr_flags next_flags;
		@(posedge clk);
		#(drive_delay);
		in_valid  = 1'b1;
		op        = o;
		a         = a_i;
		base      = base_i;
		shift     = sh;
		kind      = k;
		set_flags = sf;
		predict(o, a_i, base_i, sh, k, sf, model_flags, exp_q, next_flags);
		model_flags = next_flags;
		strobed     = 1'b1;
		vectors++;
	endtask

	task automatic end_test(input string name);
		@(posedge clk);
		#(drive_delay);
		in_valid = 1'b0;
		repeat (2) @(posedge clk);   // let the last result reach the checks
		$display("%s: %0d vectors, %0d errors", name, vectors - vec_mark, errors - err_mark);
		vec_mark = vectors;
		err_mark = errors;
	endtask

	task automatic reset_idle();
		repeat (3) @(posedge clk);
		end_test("reset");
	endtask

	task automatic arith_vectors();
		logic [core_w - 1:0] xs [6] = '{16'h7fff, 16'hffff, 16'h8000, 16'h0003, 16'h8000, 16'h1234};
		logic [core_w - 1:0] ys [6] = '{16'h0001, 16'h0001, 16'h8000, 16'h0005, 16'h0001, 16'h1234};
		alu_op ops [8] = '{alu_add, alu_adc, alu_sub, alu_sbc, alu_rsb, alu_rsc, alu_cmp, alu_cmn};
		for (int p = 0; p < 6; p++) begin
			for (int ci = 0; ci < 2; ci++) begin
				for (int j = 0; j < 8; j++) begin
					// a compare of ci against 1 - ci leaves C equal to ci
					drive_vector(alu_cmp, core_w'(ci), core_w'(1 - ci), 8'd0, shift_lsl, 1'b1);
					drive_vector(ops[j], xs[p], ys[p], 8'd0, shift_lsl, 1'b1);
				end
			end
		end
		end_test("arith");
	endtask

	task automatic logic_vectors();
		alu_op ops [8] = '{alu_and, alu_eor, alu_orr, alu_bic, alu_mov, alu_mvn, alu_tst, alu_teq};
		for (int j = 0; j < 8; j++) begin
			for (int vs = 0; vs < 2; vs++) begin
				drive_vector(alu_add, vs ? 16'h7fff : 16'h0001, 16'h0001, 8'd0, shift_lsl, 1'b1);
				drive_vector(ops[j], 16'h0ff0, 16'h8001, 8'd1, shift_lsr, 1'b1);   // shifter C is 1
				drive_vector(ops[j], 16'h0ff0, 16'h4002, 8'd1, shift_lsl, 1'b1);   // shifter C is 0
			end
		end
		end_test("logic");
	endtask

	task automatic shifter_corners();
		logic [7:0]          amts [6]  = '{8'd0, 8'd1, 8'd15, 8'd16, 8'd17, 8'd200};
		logic [core_w - 1:0] bases [2] = '{16'h8001, 16'h7ffe};
		for (int k = 0; k < 4; k++) begin
			for (int m = 0; m < 6; m++) begin
				for (int bi = 0; bi < 2; bi++)
					drive_vector(alu_mov, 16'h0000, bases[bi], amts[m], shift_kind'(k), 1'b1);
			end
		end
		end_test("shifter");
	endtask

	task automatic flag_gating();
		drive_vector(alu_add, 16'hffff, 16'h0001, 8'd0, shift_lsl, 1'b1);
		drive_vector(alu_sub, 16'h0005, 16'h0003, 8'd0, shift_lsl, 1'b0);
		drive_vector(alu_adc, 16'h0001, 16'h0001, 8'd0, shift_lsl, 1'b1);   // carry 1 kept
		drive_vector(alu_cmp, 16'h0000, 16'h0001, 8'd0, shift_lsl, 1'b1);
		drive_vector(alu_add, 16'hffff, 16'h0001, 8'd0, shift_lsl, 1'b0);
		drive_vector(alu_adc, 16'h0001, 16'h0001, 8'd0, shift_lsl, 1'b1);
		end_test("gating");
	endtask

	task automatic random_burst();
		logic [31:0] r0;
		logic [31:0] r1;
		logic [7:0]  sh;
		for (int i = 0; i < n_random; i++) begin
			r0 = $random(seed);
			r1 = $random(seed);
			// half of the amounts stay below 20 where the shifter corners live
			sh = r1[8] ? r1[7:0] : r1[7:0] % 8'd20;
			drive_vector(alu_op'(r0[3:0]), r0[31:16], r1[31:16], sh, shift_kind'(r0[5:4]), r0[6]);
		end
		end_test("random");
	endtask

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		in_valid    = 1'b0;
		op          = alu_and;
		set_flags   = 1'b0;
		a           = '0;
		base        = '0;
		shift       = '0;
		kind        = shift_lsl;
		model_flags = '0;
		exp_q       = '0;
		strobed     = 1'b0;
		seed        = 32'h51a71ac4;
		errors      = 0;
		vectors     = 0;
		err_mark    = 0;
		vec_mark    = 0;
		repeat (10) @(posedge clk);
		#(drive_delay);
		rst_n = 1'b1;
		reset_idle();
		arith_vectors();
		logic_vectors();
		shifter_corners();
		flag_gating();
		random_burst();
		$display("tests: 6, vectors: %0d, errors: %0d", vectors, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial begin
		#((n_vectors + 100) * clk_period);
		$display("simulation hung: no finish after %0t, %0d vectors sent", $time, vectors);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
